// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int XLEN = 32;  // Data and address width

  // Board I/O field widths
  localparam int LEDR_W     = 17;
  localparam int LEDG_W     = 8;
  localparam int HEX_DIGITS = 8;
  localparam int SEG_W      = 7;
  localparam int SW_W       = 10;

  // Address map
  localparam logic [XLEN-1:0] SRAM_BASE   = 32'h0000_2000;
  localparam logic [XLEN-1:0] LEDR_BASE   = 32'h0000_7000;
  localparam logic [XLEN-1:0] LEDR_LAST   = 32'h0000_700F;
  localparam logic [XLEN-1:0] LEDG_BASE   = 32'h0000_7010;
  localparam logic [XLEN-1:0] LEDG_LAST   = 32'h0000_701F;
  localparam logic [XLEN-1:0] HEX_LO_ADDR = 32'h0000_7020;  // Digits 0 to 3
  localparam logic [XLEN-1:0] HEX_HI_ADDR = 32'h0000_7024;  // Digits 4 to 7
  localparam logic [XLEN-1:0] SW_BASE     = 32'h0000_7800;
  localparam logic [XLEN-1:0] SW_LAST     = 32'h0000_780F;

  // Access size, same encoding as funct3
  typedef enum logic [2:0] {
    LSU_B  = 3'b000,
    LSU_H  = 3'b001,
    LSU_W  = 3'b010,
    LSU_BU = 3'b100,
    LSU_HU = 3'b101
  } lsu_size_e;

  // Target of a decoded access
  typedef enum logic [2:0] {
    REGION_NONE   = 3'd0,
    REGION_SRAM   = 3'd1,
    REGION_LEDR   = 3'd2,
    REGION_LEDG   = 3'd3,
    REGION_HEX_LO = 3'd4,
    REGION_HEX_HI = 3'd5,
    REGION_SWITCH = 3'd6
  } lsu_region_e;

endpackage

`default_nettype wire

// File: design/lsu_addr_decode.sv
`default_nettype none

module lsu_addr_decode #(
  parameter  int SRAM_WORDS = 2048,
  localparam int IDX_W      = $clog2(SRAM_WORDS)
) (
  input  wire                               i_clk,
  input  wire                               i_rst,
  input  wire                               i_lsu_rden,
  input  wire                               i_lsu_wren,
  input  wire  [lsu_pkg::XLEN-1:0]          i_lsu_addr,
  input  wire  lsu_pkg::lsu_size_e          i_funct3,
  input  wire  [lsu_pkg::XLEN-1:0]          i_st_data,
  output logic                              o_wr,
  output logic                              o_rd,
  output lsu_pkg::lsu_region_e              o_region,
  output logic [3:0]                        o_byte_en,
  output logic [IDX_W-1:0]                  o_word_idx,
  output logic [lsu_pkg::XLEN-1:0]          o_lane_data,
  output logic [1:0]                        o_offset,
  output lsu_pkg::lsu_size_e                o_size
);

  localparam logic [lsu_pkg::XLEN-1:0] SRAM_LAST = lsu_pkg::SRAM_BASE + 4 * SRAM_WORDS - 1;

  logic [1:0]                offset;
  logic [lsu_pkg::XLEN-1:0]  addr_rel;  // Byte address inside the RAM
  lsu_pkg::lsu_region_e      region;
  logic                      legal;
  logic [3:0]                byte_en;

  assign offset   = i_lsu_addr[1:0];
  assign addr_rel = i_lsu_addr - lsu_pkg::SRAM_BASE;

  always_comb begin
    if (i_lsu_addr >= lsu_pkg::SRAM_BASE && i_lsu_addr <= SRAM_LAST) begin
      region = lsu_pkg::REGION_SRAM;
    end else if (i_lsu_addr >= lsu_pkg::LEDR_BASE && i_lsu_addr <= lsu_pkg::LEDR_LAST) begin
      region = lsu_pkg::REGION_LEDR;
    end else if (i_lsu_addr >= lsu_pkg::LEDG_BASE && i_lsu_addr <= lsu_pkg::LEDG_LAST) begin
      region = lsu_pkg::REGION_LEDG;
    end else if (i_lsu_addr[31:2] == lsu_pkg::HEX_LO_ADDR[31:2]) begin
      region = lsu_pkg::REGION_HEX_LO;
    end else if (i_lsu_addr[31:2] == lsu_pkg::HEX_HI_ADDR[31:2]) begin
      region = lsu_pkg::REGION_HEX_HI;
    end else if (i_lsu_addr >= lsu_pkg::SW_BASE && i_lsu_addr <= lsu_pkg::SW_LAST) begin
      region = lsu_pkg::REGION_SWITCH;
    end else begin
      region = lsu_pkg::REGION_NONE;  // Unmapped
    end
  end

  // An access is legal only when all its bytes sit in one word
  always_comb begin
    legal   = 1'b0;
    byte_en = 4'b0000;
    case (i_funct3)
      lsu_pkg::LSU_B, lsu_pkg::LSU_BU: begin
        legal   = 1'b1;
        byte_en = 4'b0001 << offset;
      end
      lsu_pkg::LSU_H, lsu_pkg::LSU_HU: begin
        legal   = (offset != 2'd3);
        byte_en = 4'b0011 << offset;
      end
      lsu_pkg::LSU_W: begin
        legal   = (offset == 2'd0);
        byte_en = 4'b1111;
      end
      default: ;  // Reserved funct3
    endcase
  end

  // Illegal loads still complete and come back as zero via REGION_NONE
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      o_wr     <= 1'b0;
      o_rd     <= 1'b0;
      o_region <= lsu_pkg::REGION_NONE;
    end else begin
      o_wr     <= i_lsu_wren && legal && (region != lsu_pkg::REGION_NONE);
      o_rd     <= i_lsu_rden;
      o_region <= (legal && (i_lsu_rden || i_lsu_wren)) ? region : lsu_pkg::REGION_NONE;
    end
  end

  always_ff @(posedge i_clk) begin
    o_byte_en   <= byte_en;
    o_word_idx  <= addr_rel[IDX_W+1:2];
    o_lane_data <= i_st_data << {offset, 3'b000};  // Onto byte lanes
    o_offset    <= offset;
    o_size      <= i_funct3;
  end

  a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_rst)
      !(i_lsu_rden && i_lsu_wren))
    else $error("read and write strobes high together");

endmodule

`default_nettype wire

// File: design/lsu_data_sram.sv
`default_nettype none

module lsu_data_sram #(
  parameter  int SRAM_WORDS = 2048,
  localparam int IDX_W      = $clog2(SRAM_WORDS)
) (
  input  wire                               i_clk,
  input  wire                               i_wr,
  input  wire                               i_rd,
  input  wire  lsu_pkg::lsu_region_e        i_region,
  input  wire  [3:0]                        i_byte_en,
  input  wire  [IDX_W-1:0]                  i_word_idx,
  input  wire  [lsu_pkg::XLEN-1:0]          i_lane_data,
  output logic [lsu_pkg::XLEN-1:0]          o_rdata
);

  logic [lsu_pkg::XLEN-1:0] mem [SRAM_WORDS];
  logic                     sram_sel;

  assign sram_sel = (i_region == lsu_pkg::REGION_SRAM);

  always_ff @(posedge i_clk) begin
    if (i_wr && sram_sel) begin
      for (int b = 0; b < 4; b++) begin
        if (i_byte_en[b]) begin
          mem[i_word_idx][8*b +: 8] <= i_lane_data[8*b +: 8];  // Byte lane write
        end
      end
    end
    if (i_rd && sram_sel) begin
      o_rdata <= mem[i_word_idx];  // Earlier stores already landed
    end
  end

  // Decode bounds the RAM range, so the index must fit the array
  a_idx_range: assert property (@(posedge i_clk)
      ((i_wr || i_rd) && sram_sel) |-> (i_word_idx < SRAM_WORDS))
    else $error("RAM word index out of range");

endmodule

`default_nettype wire

// File: design/lsu_io_regs.sv
`default_nettype none

module lsu_io_regs (
  input  wire                               i_clk,
  input  wire                               i_rst,
  input  wire                               i_wr,
  input  wire  lsu_pkg::lsu_region_e        i_region,
  input  wire  [3:0]                        i_byte_en,
  input  wire  [lsu_pkg::XLEN-1:0]          i_lane_data,
  input  wire  [lsu_pkg::SW_W-1:0]          i_io_sw,
  output logic [lsu_pkg::XLEN-1:0]          o_rdata,
  output logic [lsu_pkg::LEDR_W-1:0]        o_io_ledr,
  output logic [lsu_pkg::LEDG_W-1:0]        o_io_ledg,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex0,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex1,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex2,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex3,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex4,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex5,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex6,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex7
);

  localparam int LEDR_PAD = lsu_pkg::XLEN - lsu_pkg::LEDR_W;
  localparam int LEDG_PAD = lsu_pkg::XLEN - lsu_pkg::LEDG_W;
  localparam int SW_PAD   = lsu_pkg::XLEN - lsu_pkg::SW_W;

  logic [7:0]               hex_q [lsu_pkg::HEX_DIGITS];  // Full bytes, bit 7 kept for reads
  logic [lsu_pkg::XLEN-1:0] ledr_word;
  logic [lsu_pkg::XLEN-1:0] ledg_word;
  logic [lsu_pkg::XLEN-1:0] ledr_next;
  logic [lsu_pkg::XLEN-1:0] ledg_next;
  logic [2:0]               hex_base;

  // Replace the enabled byte lanes of a word
  function automatic logic [lsu_pkg::XLEN-1:0] merge_lanes(
    input logic [lsu_pkg::XLEN-1:0] old_word,
    input logic [lsu_pkg::XLEN-1:0] new_word,
    input logic [3:0]               be
  );
    logic [lsu_pkg::XLEN-1:0] w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return w;
  endfunction

  assign ledr_word = {{LEDR_PAD{1'b0}}, o_io_ledr};
  assign ledg_word = {{LEDG_PAD{1'b0}}, o_io_ledg};
  assign ledr_next = merge_lanes(ledr_word, i_lane_data, i_byte_en);
  assign ledg_next = merge_lanes(ledg_word, i_lane_data, i_byte_en);
  assign hex_base  = (i_region == lsu_pkg::REGION_HEX_HI) ? 3'd4 : 3'd0;  // Digit word select

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      o_io_ledr <= '0;
      o_io_ledg <= '0;
      for (int d = 0; d < lsu_pkg::HEX_DIGITS; d++) begin
        hex_q[d] <= 8'h00;
      end
    end else if (i_wr) begin
      case (i_region)
        lsu_pkg::REGION_LEDR: o_io_ledr <= ledr_next[lsu_pkg::LEDR_W-1:0];  // Masked
        lsu_pkg::REGION_LEDG: o_io_ledg <= ledg_next[lsu_pkg::LEDG_W-1:0];
        lsu_pkg::REGION_HEX_LO, lsu_pkg::REGION_HEX_HI: begin
          for (int b = 0; b < 4; b++) begin
            if (i_byte_en[b]) begin
              hex_q[hex_base + b] <= i_lane_data[8*b +: 8];
            end
          end
        end
        default: ;  // Switches are read only
      endcase
    end
  end

  // Read word for the access stage, switches sampled here
  always_ff @(posedge i_clk) begin
    case (i_region)
      lsu_pkg::REGION_LEDR:   o_rdata <= ledr_word;
      lsu_pkg::REGION_LEDG:   o_rdata <= ledg_word;
      lsu_pkg::REGION_HEX_LO: o_rdata <= {hex_q[3], hex_q[2], hex_q[1], hex_q[0]};
      lsu_pkg::REGION_HEX_HI: o_rdata <= {hex_q[7], hex_q[6], hex_q[5], hex_q[4]};
      lsu_pkg::REGION_SWITCH: o_rdata <= {{SW_PAD{1'b0}}, i_io_sw};
      default:                o_rdata <= '0;
    endcase
  end

  assign o_io_hex0 = hex_q[0][lsu_pkg::SEG_W-1:0];
  assign o_io_hex1 = hex_q[1][lsu_pkg::SEG_W-1:0];
  assign o_io_hex2 = hex_q[2][lsu_pkg::SEG_W-1:0];
  assign o_io_hex3 = hex_q[3][lsu_pkg::SEG_W-1:0];
  assign o_io_hex4 = hex_q[4][lsu_pkg::SEG_W-1:0];
  assign o_io_hex5 = hex_q[5][lsu_pkg::SEG_W-1:0];
  assign o_io_hex6 = hex_q[6][lsu_pkg::SEG_W-1:0];
  assign o_io_hex7 = hex_q[7][lsu_pkg::SEG_W-1:0];

endmodule

`default_nettype wire

// File: design/lsu_load_align.sv
`default_nettype none

module lsu_load_align (
  input  wire                               i_clk,
  input  wire                               i_rst,
  input  wire                               i_rd,
  input  wire  lsu_pkg::lsu_region_e        i_region,
  input  wire  [1:0]                        i_offset,
  input  wire  lsu_pkg::lsu_size_e          i_size,
  input  wire  [lsu_pkg::XLEN-1:0]          i_sram_rdata,
  input  wire  [lsu_pkg::XLEN-1:0]          i_io_rdata,
  output logic [lsu_pkg::XLEN-1:0]          o_ld_data,
  output logic                              o_ld_valid
);

  logic                     rd_q;
  lsu_pkg::lsu_region_e     region_q;
  logic [1:0]               offset_q;
  lsu_pkg::lsu_size_e       size_q;
  logic [lsu_pkg::XLEN-1:0] src_word;
  logic [lsu_pkg::XLEN-1:0] shifted;
  logic [lsu_pkg::XLEN-1:0] ext_data;

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      rd_q       <= 1'b0;
      o_ld_valid <= 1'b0;
    end else begin
      rd_q       <= i_rd;
      o_ld_valid <= rd_q;  // Result pulse
    end
  end

  // Line up the stage-1 controls with the read words
  always_ff @(posedge i_clk) begin
    region_q <= i_region;
    offset_q <= i_offset;
    size_q   <= i_size;
  end

  always_comb begin
    case (region_q)
      lsu_pkg::REGION_NONE: src_word = '0;  // Unmapped or illegal
      lsu_pkg::REGION_SRAM: src_word = i_sram_rdata;
      default:              src_word = i_io_rdata;
    endcase
  end

  assign shifted = src_word >> {offset_q, 3'b000};

  always_comb begin
    case (size_q)
      lsu_pkg::LSU_B:  ext_data = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::LSU_BU: ext_data = {24'h00_0000, shifted[7:0]};
      lsu_pkg::LSU_H:  ext_data = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::LSU_HU: ext_data = {16'h0000, shifted[15:0]};
      lsu_pkg::LSU_W:  ext_data = shifted;
      default:         ext_data = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (rd_q) begin
      o_ld_data <= ext_data;
    end
  end

  a_valid_follows_rd: assert property (@(posedge i_clk) disable iff (!i_rst)
      i_rd |-> ##2 (o_ld_valid && !$isunknown(o_ld_data)))
    else $error("load result missing or unknown two cycles after read strobe");

endmodule

`default_nettype wire

// File: design/lsu_top.sv
`default_nettype none

module lsu_top #(
  parameter  int SRAM_WORDS = 2048,
  localparam int IDX_W      = $clog2(SRAM_WORDS)
) (
  input  wire                               i_clk,
  input  wire                               i_rst,
  input  wire                               i_lsu_rden,
  input  wire                               i_lsu_wren,
  input  wire  [lsu_pkg::XLEN-1:0]          i_lsu_addr,
  input  wire  lsu_pkg::lsu_size_e          i_funct3,
  input  wire  [lsu_pkg::XLEN-1:0]          i_st_data,
  input  wire  [lsu_pkg::SW_W-1:0]          i_io_sw,
  output logic [lsu_pkg::XLEN-1:0]          o_ld_data,
  output logic                              o_ld_valid,
  output logic [lsu_pkg::LEDR_W-1:0]        o_io_ledr,
  output logic [lsu_pkg::LEDG_W-1:0]        o_io_ledg,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex0,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex1,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex2,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex3,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex4,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex5,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex6,
  output logic [lsu_pkg::SEG_W-1:0]         o_io_hex7
);

  // Stage 1 outputs
  logic                      s1_wr;
  logic                      s1_rd;
  lsu_pkg::lsu_region_e      s1_region;
  logic [3:0]                s1_byte_en;
  logic [IDX_W-1:0]          s1_word_idx;
  logic [lsu_pkg::XLEN-1:0]  s1_lane_data;
  logic [1:0]                s1_offset;
  lsu_pkg::lsu_size_e        s1_size;

  // Access stage read words
  logic [lsu_pkg::XLEN-1:0]  sram_rdata;
  logic [lsu_pkg::XLEN-1:0]  io_rdata;

  lsu_addr_decode #(
    .SRAM_WORDS (SRAM_WORDS)
  ) u_decode (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_lsu_rden  (i_lsu_rden),
    .i_lsu_wren  (i_lsu_wren),
    .i_lsu_addr  (i_lsu_addr),
    .i_funct3    (i_funct3),
    .i_st_data   (i_st_data),
    .o_wr        (s1_wr),
    .o_rd        (s1_rd),
    .o_region    (s1_region),
    .o_byte_en   (s1_byte_en),
    .o_word_idx  (s1_word_idx),
    .o_lane_data (s1_lane_data),
    .o_offset    (s1_offset),
    .o_size      (s1_size)
  );

  lsu_data_sram #(
    .SRAM_WORDS (SRAM_WORDS)
  ) u_sram (
    .i_clk       (i_clk),
    .i_wr        (s1_wr),
    .i_rd        (s1_rd),
    .i_region    (s1_region),
    .i_byte_en   (s1_byte_en),
    .i_word_idx  (s1_word_idx),
    .i_lane_data (s1_lane_data),
    .o_rdata     (sram_rdata)
  );

  lsu_io_regs u_io (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_wr        (s1_wr),
    .i_region    (s1_region),
    .i_byte_en   (s1_byte_en),
    .i_lane_data (s1_lane_data),
    .i_io_sw     (i_io_sw),
    .o_rdata     (io_rdata),
    .o_io_ledr   (o_io_ledr),
    .o_io_ledg   (o_io_ledg),
    .o_io_hex0   (o_io_hex0),
    .o_io_hex1   (o_io_hex1),
    .o_io_hex2   (o_io_hex2),
    .o_io_hex3   (o_io_hex3),
    .o_io_hex4   (o_io_hex4),
    .o_io_hex5   (o_io_hex5),
    .o_io_hex6   (o_io_hex6),
    .o_io_hex7   (o_io_hex7)
  );

  lsu_load_align u_align (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_rd         (s1_rd),
    .i_region     (s1_region),
    .i_offset     (s1_offset),
    .i_size       (s1_size),
    .i_sram_rdata (sram_rdata),
    .i_io_rdata   (io_rdata),
    .o_ld_data    (o_ld_data),
    .o_ld_valid   (o_ld_valid)
  );

endmodule

`default_nettype wire

// File: verif/lsu_tb.sv
`default_nettype none

module lsu_tb;

  localparam int XLEN          = lsu_pkg::XLEN;
  localparam int SEG_W         = lsu_pkg::SEG_W;
  localparam int SRAM_WORDS    = 2048;
  localparam int DRIVE_DELAY   = 10;
  localparam int LOAD_TIMEOUT  = 8;    // Cycles from issue to result pulse
  localparam int RESULT_DELAY  = 4;    // Falling edges from issue to the result sample
  localparam int DRAIN_TIMEOUT = 200;
  localparam logic [XLEN-1:0] SRAM_BASE = lsu_pkg::SRAM_BASE;

  logic                      i_clk;
  logic                      i_rst;
  logic                      i_lsu_rden;
  logic                      i_lsu_wren;
  logic [XLEN-1:0]           i_lsu_addr;
  lsu_pkg::lsu_size_e        i_funct3;
  logic [XLEN-1:0]           i_st_data;
  logic [lsu_pkg::SW_W-1:0]  i_io_sw;
  wire  [XLEN-1:0]           o_ld_data;
  wire                       o_ld_valid;
  wire  [lsu_pkg::LEDR_W-1:0] o_io_ledr;
  wire  [lsu_pkg::LEDG_W-1:0] o_io_ledg;
  wire  [SEG_W-1:0]          o_io_hex0;
  wire  [SEG_W-1:0]          o_io_hex1;
  wire  [SEG_W-1:0]          o_io_hex2;
  wire  [SEG_W-1:0]          o_io_hex3;
  wire  [SEG_W-1:0]          o_io_hex4;
  wire  [SEG_W-1:0]          o_io_hex5;
  wire  [SEG_W-1:0]          o_io_hex6;
  wire  [SEG_W-1:0]          o_io_hex7;
  wire  [8*SEG_W-1:0]        hex_bus;

  logic [7:0]                ram_model [4*SRAM_WORDS];  // Byte-addressed RAM shadow
  logic [XLEN-1:0]           ledr_model;
  logic [XLEN-1:0]           ledg_model;
  logic [7:0]                hex_model [8];
  logic [XLEN-1:0]           exp_q [$];
  string                     name_q [$];
  int                        issue_q [$];
  logic [XLEN-1:0]           exp_val;
  string                     name_val;
  int                        issue_val;
  int                        cycle_cnt = 0;
  int                        check_cnt = 0;
  int                        mismatch_cnt = 0;
  int                        other_cnt = 0;
  integer                    seed;
  lsu_pkg::lsu_size_e        size_list [5];
  logic [XLEN-1:0]           rnd;
  logic [XLEN-1:0]           word_addr;

  assign hex_bus = {o_io_hex7, o_io_hex6, o_io_hex5, o_io_hex4,
                    o_io_hex3, o_io_hex2, o_io_hex1, o_io_hex0};

  lsu_top #(
    .SRAM_WORDS (SRAM_WORDS)
  ) UUT (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_lsu_rden (i_lsu_rden),
    .i_lsu_wren (i_lsu_wren),
    .i_lsu_addr (i_lsu_addr),
    .i_funct3   (i_funct3),
    .i_st_data  (i_st_data),
    .i_io_sw    (i_io_sw),
    .o_ld_data  (o_ld_data),
    .o_ld_valid (o_ld_valid),
    .o_io_ledr  (o_io_ledr),
    .o_io_ledg  (o_io_ledg),
    .o_io_hex0  (o_io_hex0),
    .o_io_hex1  (o_io_hex1),
    .o_io_hex2  (o_io_hex2),
    .o_io_hex3  (o_io_hex3),
    .o_io_hex4  (o_io_hex4),
    .o_io_hex5  (o_io_hex5),
    .o_io_hex6  (o_io_hex6),
    .o_io_hex7  (o_io_hex7)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic int access_bytes(input lsu_pkg::lsu_size_e size);
    case (size)
      lsu_pkg::LSU_W:                  return 4;
      lsu_pkg::LSU_H, lsu_pkg::LSU_HU: return 2;
      default:                         return 1;
    endcase
  endfunction

  // All bytes of the access must land in one word
  function automatic bit fits_word(input logic [XLEN-1:0] addr, input lsu_pkg::lsu_size_e size);
    return (int'(addr[1:0]) + access_bytes(size)) <= 4;
  endfunction

  function automatic lsu_pkg::lsu_region_e region_of(input logic [XLEN-1:0] addr);
    if (addr >= SRAM_BASE && addr < SRAM_BASE + 4 * SRAM_WORDS) return lsu_pkg::REGION_SRAM;
    if (addr >= lsu_pkg::LEDR_BASE && addr <= lsu_pkg::LEDR_LAST) return lsu_pkg::REGION_LEDR;
    if (addr >= lsu_pkg::LEDG_BASE && addr <= lsu_pkg::LEDG_LAST) return lsu_pkg::REGION_LEDG;
    if (addr >= lsu_pkg::HEX_LO_ADDR && addr < lsu_pkg::HEX_LO_ADDR + 4) return lsu_pkg::REGION_HEX_LO;
    if (addr >= lsu_pkg::HEX_HI_ADDR && addr < lsu_pkg::HEX_HI_ADDR + 4) return lsu_pkg::REGION_HEX_HI;
    if (addr >= lsu_pkg::SW_BASE && addr <= lsu_pkg::SW_LAST) return lsu_pkg::REGION_SWITCH;
    return lsu_pkg::REGION_NONE;
  endfunction

  function automatic logic [XLEN-1:0] model_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] base;
    base = {addr[XLEN-1:2], 2'b00} - SRAM_BASE;
    case (region_of(addr))
      lsu_pkg::REGION_SRAM:   return {ram_model[base+3], ram_model[base+2],
                                      ram_model[base+1], ram_model[base]};
      lsu_pkg::REGION_LEDR:   return ledr_model;
      lsu_pkg::REGION_LEDG:   return ledg_model;
      lsu_pkg::REGION_HEX_LO: return {hex_model[3], hex_model[2], hex_model[1], hex_model[0]};
      lsu_pkg::REGION_HEX_HI: return {hex_model[7], hex_model[6], hex_model[5], hex_model[4]};
      lsu_pkg::REGION_SWITCH: return {{(XLEN-lsu_pkg::SW_W){1'b0}}, i_io_sw};
      default:                return '0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] ref_load(input logic [XLEN-1:0] addr,
                                               input lsu_pkg::lsu_size_e size);
    logic [XLEN-1:0] word;
    int              off;
    if (!fits_word(addr, size)) return '0;  // Illegal load reads zero
    word = model_word(addr);
    off  = 8 * addr[1:0];
    case (size)
      lsu_pkg::LSU_B:  return {{24{word[off+7]}}, word[off +: 8]};
      lsu_pkg::LSU_BU: return {24'h0, word[off +: 8]};
      lsu_pkg::LSU_H:  return {{16{word[off+15]}}, word[off +: 16]};
      lsu_pkg::LSU_HU: return {16'h0, word[off +: 16]};
      default:         return word;
    endcase
  endfunction

  function automatic void ref_store(input logic [XLEN-1:0] addr, input lsu_pkg::lsu_size_e size,
                                    input logic [XLEN-1:0] data);
    logic [XLEN-1:0] base;
    int              lane;
    base = {addr[XLEN-1:2], 2'b00} - SRAM_BASE;
    if (!fits_word(addr, size)) return;
    for (int b = 0; b < access_bytes(size); b++) begin
      lane = int'(addr[1:0]) + b;
      case (region_of(addr))
        lsu_pkg::REGION_SRAM:   ram_model[base+lane] = data[8*b +: 8];
        lsu_pkg::REGION_LEDR:   ledr_model[8*lane +: 8] = data[8*b +: 8];
        lsu_pkg::REGION_LEDG:   ledg_model[8*lane +: 8] = data[8*b +: 8];
        lsu_pkg::REGION_HEX_LO: hex_model[lane] = data[8*b +: 8];
        lsu_pkg::REGION_HEX_HI: hex_model[4+lane] = data[8*b +: 8];
        default: ;
      endcase
    end
    ledr_model[XLEN-1:lsu_pkg::LEDR_W] = '0;  // Register widths
    ledg_model[XLEN-1:lsu_pkg::LEDG_W] = '0;
  endfunction

  function automatic logic [XLEN-1:0] fill_pattern(input logic [XLEN-1:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
  endfunction

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_ledr(input string name, input logic [lsu_pkg::LEDR_W-1:0] exp,
                            input logic [lsu_pkg::LEDR_W-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_ledg(input string name, input logic [lsu_pkg::LEDG_W-1:0] exp,
                            input logic [lsu_pkg::LEDG_W-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_hex(input string name, input logic [SEG_W-1:0] exp,
                           input logic [SEG_W-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_outputs(input string name);
    check_ledr({name, "_ledr"}, ledr_model[lsu_pkg::LEDR_W-1:0], o_io_ledr);
    check_ledg({name, "_ledg"}, ledg_model[lsu_pkg::LEDG_W-1:0], o_io_ledg);
    for (int d = 0; d < 8; d++) begin
      check_hex($sformatf("%s_hex%0d", name, d), hex_model[d][SEG_W-1:0],
                hex_bus[d*SEG_W +: SEG_W]);
    end
  endtask

  task automatic issue_store(input logic [XLEN-1:0] addr, input lsu_pkg::lsu_size_e size,
                             input logic [XLEN-1:0] data);
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_lsu_wren = 1'b1;
    i_lsu_rden = 1'b0;
    i_lsu_addr = addr;
    i_funct3   = size;
    i_st_data  = data;
    ref_store(addr, size, data);
  endtask

  task automatic issue_load(input string name, input logic [XLEN-1:0] addr,
                            input lsu_pkg::lsu_size_e size);
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_lsu_wren = 1'b0;
    i_lsu_rden = 1'b1;
    i_lsu_addr = addr;
    i_funct3   = size;
    i_st_data  = '0;
    exp_q.push_back(ref_load(addr, size));
    name_q.push_back(name);
    issue_q.push_back(cycle_cnt);
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles) begin
      @(posedge i_clk);
      #DRIVE_DELAY;
      i_lsu_wren = 1'b0;
      i_lsu_rden = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge i_clk);
      waited++;
    end
    if (exp_q.size() > 0) begin
      other_cnt++;
      $display("timeout with %0d load results still outstanding", exp_q.size());
    end
  endtask

  // Results sampled mid-cycle in issue order
  always @(negedge i_clk) begin
    cycle_cnt++;
    if (o_ld_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_cnt++;
        $display("load result pulse with no load outstanding");
      end else begin
        exp_val   = exp_q.pop_front();
        name_val  = name_q.pop_front();
        issue_val = issue_q.pop_front();
        check_word(name_val, exp_val, o_ld_data);
        if (cycle_cnt - issue_val != RESULT_DELAY) begin
          other_cnt++;
          $display("load %s result arrived %0d cycles after issue instead of %0d",
                   name_val, cycle_cnt - issue_val, RESULT_DELAY);
        end
      end
    end else if (issue_q.size() > 0 && cycle_cnt - issue_q[0] > LOAD_TIMEOUT) begin
      other_cnt++;
      $display("load %s got no result pulse in %0d cycles", name_q[0], LOAD_TIMEOUT);
      exp_val   = exp_q.pop_front();
      name_val  = name_q.pop_front();
      issue_val = issue_q.pop_front();
    end
  end

  initial begin
    seed = 32'h27df_1ca0;
    size_list[0] = lsu_pkg::LSU_B;
    size_list[1] = lsu_pkg::LSU_H;
    size_list[2] = lsu_pkg::LSU_W;
    size_list[3] = lsu_pkg::LSU_BU;
    size_list[4] = lsu_pkg::LSU_HU;
    i_rst      = 1'b0;
    i_lsu_rden = 1'b0;
    i_lsu_wren = 1'b0;
    i_lsu_addr = '0;
    i_funct3   = lsu_pkg::LSU_W;
    i_st_data  = '0;
    i_io_sw    = '0;
    ledr_model = '0;
    ledg_model = '0;
    for (int d = 0; d < 8; d++) begin
      hex_model[d] = 8'h00;
    end
    repeat (5) @(posedge i_clk);
    #DRIVE_DELAY;
    i_rst = 1'b1;
    go_idle(2);
    check_outputs("reset");

    // Every RAM word gets a known value first
    for (int w = 0; w < SRAM_WORDS; w++) begin
      issue_store(SRAM_BASE + 4 * w, lsu_pkg::LSU_W, fill_pattern(SRAM_BASE + 4 * w));
    end

    // Random store, then all sizes at all offsets of that word
    repeat (40) begin
      word_addr = SRAM_BASE + 4 * ($unsigned($random(seed)) % SRAM_WORDS);
      rnd       = $random(seed);
      issue_store(word_addr + rnd[1:0], size_list[rnd[5:4] % 3], $random(seed));
      for (int s = 0; s < 5; s++) begin
        for (int off = 0; off < 4; off++) begin
          issue_load("sram_rand", word_addr + off, size_list[s]);
        end
      end
    end
    go_idle(1);
    wait_drain();

    issue_store(lsu_pkg::LEDR_BASE, lsu_pkg::LSU_W, 32'hFFFF_FFFF);
    issue_store(lsu_pkg::LEDR_BASE + 5, lsu_pkg::LSU_H, 32'h0000_1335);
    issue_store(lsu_pkg::LEDR_BASE + 10, lsu_pkg::LSU_B, 32'h0000_0054);  // Bit 16 cleared
    issue_store(lsu_pkg::LEDG_BASE + 8, lsu_pkg::LSU_W, $random(seed));
    issue_store(lsu_pkg::LEDG_BASE + 3, lsu_pkg::LSU_B, 32'h0000_00A5);  // Above LEDG width
    go_idle(3);
    check_outputs("led_store");
    issue_load("ledr_lw", lsu_pkg::LEDR_BASE, lsu_pkg::LSU_W);
    issue_load("ledr_lhu", lsu_pkg::LEDR_BASE + 2, lsu_pkg::LSU_HU);
    issue_load("ledg_lb", lsu_pkg::LEDG_BASE + 12, lsu_pkg::LSU_B);

    issue_store(lsu_pkg::HEX_LO_ADDR, lsu_pkg::LSU_W, 32'h7F06_5B4F);
    issue_store(lsu_pkg::HEX_HI_ADDR + 2, lsu_pkg::LSU_H, 32'h0000_E6ED);
    issue_store(lsu_pkg::HEX_HI_ADDR, lsu_pkg::LSU_B, 32'h0000_0066);
    issue_store(lsu_pkg::HEX_LO_ADDR + 1, lsu_pkg::LSU_B, 32'h0000_0080);
    issue_store(lsu_pkg::HEX_HI_ADDR + 3, lsu_pkg::LSU_H, 32'h0000_FFFF);  // Illegal
    go_idle(3);
    check_outputs("hex_store");
    issue_load("hex_lo_lw", lsu_pkg::HEX_LO_ADDR, lsu_pkg::LSU_W);
    issue_load("hex_hi_lw", lsu_pkg::HEX_HI_ADDR, lsu_pkg::LSU_W);
    issue_load("hex_lbu", lsu_pkg::HEX_LO_ADDR + 1, lsu_pkg::LSU_BU);
    issue_load("hex_lb", lsu_pkg::HEX_HI_ADDR + 3, lsu_pkg::LSU_B);
    issue_load("hex_lh", lsu_pkg::HEX_HI_ADDR + 2, lsu_pkg::LSU_H);
    go_idle(1);
    wait_drain();

    #DRIVE_DELAY;
    rnd     = $random(seed);
    i_io_sw = rnd[lsu_pkg::SW_W-1:0];
    go_idle(2);
    issue_load("sw_lw", lsu_pkg::SW_BASE, lsu_pkg::LSU_W);
    issue_load("sw_alias_lw", lsu_pkg::SW_BASE + 12, lsu_pkg::LSU_W);
    issue_load("sw_lb", lsu_pkg::SW_BASE, lsu_pkg::LSU_B);
    issue_load("sw_lhu", lsu_pkg::SW_BASE + 1, lsu_pkg::LSU_HU);
    issue_store(32'h0000_0100, lsu_pkg::LSU_W, 32'h1111_2222);  // Unmapped, no effect
    issue_load("unmapped_low", 32'h0000_0100, lsu_pkg::LSU_W);
    issue_load("unmapped_ram_end", SRAM_BASE + 4 * SRAM_WORDS, lsu_pkg::LSU_W);
    issue_load("unmapped_hex_gap", 32'h0000_7028, lsu_pkg::LSU_W);
    issue_load("unmapped_sw_end", 32'h0000_7810, lsu_pkg::LSU_W);
    issue_load("unmapped_top", 32'hFFFF_FFFF, lsu_pkg::LSU_B);

    word_addr = SRAM_BASE + 32'h40;
    issue_store(word_addr, lsu_pkg::LSU_W, 32'h8765_4321);
    issue_load("b2b_word", word_addr, lsu_pkg::LSU_W);
    issue_store(word_addr + 3, lsu_pkg::LSU_B, 32'h0000_00C3);
    issue_load("b2b_byte", word_addr + 3, lsu_pkg::LSU_B);
    issue_store(word_addr + 2, lsu_pkg::LSU_H, 32'h0000_9ABC);
    issue_load("b2b_half", word_addr, lsu_pkg::LSU_W);
    issue_store(word_addr + 2, lsu_pkg::LSU_W, 32'hDEAD_BEEF);
    issue_load("b2b_illegal_lw", word_addr + 2, lsu_pkg::LSU_W);
    issue_load("b2b_after_illegal", word_addr, lsu_pkg::LSU_W);
    issue_store(lsu_pkg::LEDG_BASE, lsu_pkg::LSU_B, 32'h0000_003C);
    issue_load("b2b_ledg", lsu_pkg::LEDG_BASE, lsu_pkg::LSU_BU);
    go_idle(1);
    wait_drain();
    go_idle(3);
    check_outputs("final");

    $display("checks %0d mismatches %0d other errors %0d", check_cnt, mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
design/lsu_pkg.sv
design/lsu_addr_decode.sv
design/lsu_data_sram.sv
design/lsu_io_regs.sv
design/lsu_load_align.sv
design/lsu_top.sv
verif/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  # RTL
  - files:
      - design/lsu_pkg.sv
      - design/lsu_addr_decode.sv
      - design/lsu_data_sram.sv
      - design/lsu_io_regs.sv
      - design/lsu_load_align.sv
      - design/lsu_top.sv

  # Testbench
  - target: simulation
    files:
      - verif/lsu_tb.sv
